/* logic/perf_defines.svh */
`ifndef PERF_DEFINES_SVH
`define PERF_DEFINES_SVH

// number of burst writers sharing the write bus.
`define PERF_NUM_GEN 4

// memory word address and beat width.
`define PERF_ADDR_W 8
`define PERF_DATA_W 32

// each writer owns a region of 2**PERF_REGION_W words.
`define PERF_REGION_W 6

`define PERF_CNT_W 16     // statistics counter width.

`define PERF_MEM_DEPTH 256     // words in the sink memory.

`endif

/* logic/perf_pkg.sv */
`default_nettype none

`include "perf_defines.svh"

package perf_pkg;

  // --------------------------------------------------
  // vector types
  // --------------------------------------------------
  typedef logic [`PERF_ADDR_W-1:0] addr_t;
  typedef logic [`PERF_DATA_W-1:0] data_t;
  typedef logic [`PERF_CNT_W-1:0] cnt_t;
  typedef logic [$clog2(`PERF_NUM_GEN)-1:0] gen_id_t;

  // --------------------------------------------------
  // structs
  // --------------------------------------------------

  // a zero in either count field is run as one.
  typedef struct packed {
    logic [3:0] num_bursts;
    logic [3:0] burst_len;
    logic [7:0] tag;
  } run_cfg_t;

  typedef struct packed {
    addr_t addr;
    data_t data;
    logic  last;     // final beat of a burst.
  } wr_beat_t;

  typedef struct packed {
    cnt_t beats;
    cnt_t busy_cycles;
    cnt_t stall_cycles;
  } run_stats_t;

  // --------------------------------------------------
  // writer FSM
  // --------------------------------------------------
  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_stream,
    st_done
  } writer_state_e;

endpackage

`default_nettype wire

/* logic/burst_writer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "perf_defines.svh"

module burst_writer #(
  parameter int GEN_ID = 0
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 start_req,
  input  perf_pkg::run_cfg_t   cfg,
  output logic                 start_ack,
  output perf_pkg::run_stats_t stats,
  output logic                 bus_req,
  input  logic                 bus_ack,
  output perf_pkg::wr_beat_t   beat,
  output logic                 beat_valid,
  input  logic                 beat_ready
);
  import perf_pkg::*;

  localparam gen_id_t ID = gen_id_t'(GEN_ID);

  writer_state_e             state;
  run_cfg_t                  run_cfg;     // latched at start, lengths of zero raised to one.
  logic [3:0]                beat_idx;    // beat within the current burst.
  logic [3:0]                burst_idx;   // bursts finished so far.
  logic                      accept;
  logic                      last_beat;
  logic                      last_burst;
  logic [`PERF_REGION_W-1:0] offset;

  assign accept     = beat_valid & beat_ready;
  assign last_beat  = beat_idx == run_cfg.burst_len - 4'd1;
  assign last_burst = burst_idx == run_cfg.num_bursts - 4'd1;

  // the running offset is the number of beats already written in this run.
  assign offset = stats.beats[`PERF_REGION_W-1:0];

  // --------------------------------------------------
  // beat and handshake outputs
  // --------------------------------------------------
  assign start_ack  = state == st_done;
  assign beat_valid = state == st_stream;

  assign beat.addr = {ID, offset};     // region base plus offset, wrapping in the region.
  assign beat.data = {run_cfg.tag, 8'(ID), stats.beats};
  assign beat.last = last_beat;

  // --------------------------------------------------
  // FSM and statistics
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= st_idle;
      run_cfg   <= '0;
      beat_idx  <= '0;
      burst_idx <= '0;
      bus_req   <= 1'b0;
      stats     <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start_req) begin
            run_cfg.tag        <= cfg.tag;
            run_cfg.burst_len  <= (cfg.burst_len == 4'd0) ? 4'd1 : cfg.burst_len;
            run_cfg.num_bursts <= (cfg.num_bursts == 4'd0) ? 4'd1 : cfg.num_bursts;
            beat_idx           <= '0;
            burst_idx          <= '0;
            stats              <= '0;
            state              <= st_request;
          end
        end

        st_request: begin
          stats.busy_cycles <= stats.busy_cycles + 1'b1;
          // the grant of the previous burst has to be withdrawn before asking again.
          if (!bus_req && !bus_ack) begin
            bus_req <= 1'b1;
          end
          if (bus_req && bus_ack) begin
            state <= st_stream;
          end
        end

        st_stream: begin
          stats.busy_cycles <= stats.busy_cycles + 1'b1;
          if (accept) begin
            stats.beats <= stats.beats + 1'b1;
            beat_idx    <= beat_idx + 4'd1;
            if (last_beat) begin
              bus_req   <= 1'b0;
              beat_idx  <= '0;
              burst_idx <= burst_idx + 4'd1;
              state     <= last_burst ? st_done : st_request;
            end
          end else begin
            stats.stall_cycles <= stats.stall_cycles + 1'b1;   // held beat under back-pressure.
          end
        end

        st_done: begin
          if (!start_req) begin
            state <= st_idle;
          end
        end

        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/write_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "perf_defines.svh"

module write_arbiter (
  input  logic                                  clk,
  input  logic                                  arst_n,
  input  logic [`PERF_NUM_GEN-1:0]              bus_req,
  output logic [`PERF_NUM_GEN-1:0]              bus_ack,
  input  perf_pkg::wr_beat_t [`PERF_NUM_GEN-1:0] beat_in,
  input  logic [`PERF_NUM_GEN-1:0]              beat_valid_in,
  output logic [`PERF_NUM_GEN-1:0]              beat_ready_out,
  output perf_pkg::wr_beat_t                    beat,
  output logic                                  beat_valid,
  input  logic                                  beat_ready
);
  import perf_pkg::*;

  localparam int N = `PERF_NUM_GEN;

  gen_id_t rr_ptr;       // most recent owner.
  gen_id_t owner;
  logic    busy;         // the bus is granted to owner.
  gen_id_t next_owner;
  logic    any_req;

  // --------------------------------------------------
  // round-robin pick
  // --------------------------------------------------

  // scan downwards so the writer closest after rr_ptr wins, the last owner comes last.
  always_comb begin
    gen_id_t idx;
    next_owner = rr_ptr;
    any_req    = 1'b0;
    for (int k = N; k >= 1; k--) begin
      idx = rr_ptr + gen_id_t'(k);
      if (bus_req[idx]) begin
        next_owner = idx;
        any_req    = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy   <= 1'b0;
      owner  <= '0;
      rr_ptr <= gen_id_t'(N - 1);    // writer 0 is served first.
    end else if (busy) begin
      if (!bus_req[owner]) begin
        busy   <= 1'b0;              // owner is done with its burst.
        rr_ptr <= owner;
      end
    end else if (any_req) begin
      busy  <= 1'b1;
      owner <= next_owner;
    end
  end

  // --------------------------------------------------
  // grant and beat routing
  // --------------------------------------------------
  always_comb begin
    bus_ack        = '0;
    beat_ready_out = '0;
    if (busy) begin
      bus_ack[owner]        = 1'b1;
      beat_ready_out[owner] = beat_ready;
    end
  end

  assign beat       = beat_in[owner];
  assign beat_valid = busy & beat_valid_in[owner];

endmodule

`default_nettype wire

/* logic/mem_sink.sv */
`timescale 1ns/1ps
`default_nettype none

`include "perf_defines.svh"

module mem_sink (
  input  logic               clk,
  input  logic               arst_n,
  input  perf_pkg::wr_beat_t beat,
  input  logic               beat_valid,
  output logic               beat_ready,
  input  perf_pkg::addr_t    rd_addr,
  output perf_pkg::data_t    rd_data
);
  import perf_pkg::*;

  // bit 0 of the seed is clear, so ready starts low.
  localparam logic [15:0] LFSR_SEED = 16'hace0;

  logic [15:0] lfsr;
  logic        feedback;
  logic        wr_en;
  data_t       mem [`PERF_MEM_DEPTH];

  // --------------------------------------------------
  // back-pressure
  // --------------------------------------------------

  // maximal length polynomial x^16 + x^14 + x^13 + x^11 + 1.
  assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lfsr <= LFSR_SEED;
    end else begin
      lfsr <= {lfsr[14:0], feedback};     // advances every cycle, traffic or not.
    end
  end

  assign beat_ready = lfsr[0];
  assign wr_en      = beat_valid & beat_ready;

  // --------------------------------------------------
  // storage and read-back
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[beat.addr] <= beat.data;
    end
    rd_data <= mem[rd_addr];     // one cycle after rd_addr.
  end

endmodule

`default_nettype wire

/* logic/perf_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "perf_defines.svh"

module perf_top (
  input  logic                                    clk,
  input  logic                                    arst_n,
  input  logic [`PERF_NUM_GEN-1:0]                start_req,
  input  perf_pkg::run_cfg_t [`PERF_NUM_GEN-1:0]   cfg,
  output logic [`PERF_NUM_GEN-1:0]                start_ack,
  output perf_pkg::run_stats_t [`PERF_NUM_GEN-1:0] stats,
  input  perf_pkg::addr_t                         rd_addr,
  output perf_pkg::data_t                         rd_data
);
  import perf_pkg::*;

  logic [`PERF_NUM_GEN-1:0]     bus_req;
  logic [`PERF_NUM_GEN-1:0]     bus_ack;
  wr_beat_t [`PERF_NUM_GEN-1:0] gen_beat;
  logic [`PERF_NUM_GEN-1:0]     gen_valid;
  logic [`PERF_NUM_GEN-1:0]     gen_ready;

  // shared bus from the arbiter into the sink.
  wr_beat_t sink_beat;
  logic     sink_valid;
  logic     sink_ready;

  generate
    for (genvar i = 0; i < `PERF_NUM_GEN; i++) begin : g_writer
      burst_writer #(
        .GEN_ID(i)
      ) u_writer (
        .clk       (clk),
        .arst_n    (arst_n),
        .start_req (start_req[i]),
        .cfg       (cfg[i]),
        .start_ack (start_ack[i]),
        .stats     (stats[i]),
        .bus_req   (bus_req[i]),
        .bus_ack   (bus_ack[i]),
        .beat      (gen_beat[i]),
        .beat_valid(gen_valid[i]),
        .beat_ready(gen_ready[i])
      );
    end
  endgenerate

  write_arbiter u_arbiter (
    .clk           (clk),
    .arst_n        (arst_n),
    .bus_req       (bus_req),
    .bus_ack       (bus_ack),
    .beat_in       (gen_beat),
    .beat_valid_in (gen_valid),
    .beat_ready_out(gen_ready),
    .beat          (sink_beat),
    .beat_valid    (sink_valid),
    .beat_ready    (sink_ready)
  );

  mem_sink u_sink (
    .clk       (clk),
    .arst_n    (arst_n),
    .beat      (sink_beat),
    .beat_valid(sink_valid),
    .beat_ready(sink_ready),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

endmodule

`default_nettype wire

/* tb/perf_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "perf_defines.svh"

module perf_assertions (
  input logic                     clk,
  input logic                     arst_n,
  input logic [`PERF_NUM_GEN-1:0] bus_req,
  input logic [`PERF_NUM_GEN-1:0] bus_ack,
  input perf_pkg::wr_beat_t       beat,
  input logic                     beat_valid,
  input logic                     beat_ready
);
  import perf_pkg::*;

  int unsigned failures = 0;     // assertion failures so far.

  // --------------------------------------------------
  // grant rules
  // --------------------------------------------------
  a_ack_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(bus_ack))
    else begin failures++; $error("bus_ack is not one-hot or zero"); end

  // a grant only appears for a writer that is asking for the bus.
  a_ack_rise: assert property (@(posedge clk) disable iff (!arst_n)
    (bus_ack & ~$past(bus_ack) & ~bus_req) == '0)
    else begin failures++; $error("bus_ack rose without bus_req"); end

  // a granted writer keeps the bus for as long as it asks for it.
  a_owner_hold: assert property (@(posedge clk) disable iff (!arst_n)
    ((bus_ack & bus_req) != '0) |=> (bus_ack == $past(bus_ack)))
    else begin failures++; $error("owner changed during a burst"); end

  // --------------------------------------------------
  // beat rules
  // --------------------------------------------------
  a_beat_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (beat_valid && !beat_ready) |=> (beat_valid && $stable(beat)))
    else begin failures++; $error("beat changed while not ready"); end

endmodule

bind write_arbiter perf_assertions u_assert (
  .clk       (clk),
  .arst_n    (arst_n),
  .bus_req   (bus_req),
  .bus_ack   (bus_ack),
  .beat      (beat),
  .beat_valid(beat_valid),
  .beat_ready(beat_ready)
);

`default_nettype wire

/* tb/perf_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "perf_defines.svh"

module perf_tb;
  import perf_pkg::*;

  localparam int N               = `PERF_NUM_GEN;
  localparam int REGION          = 2 ** `PERF_REGION_W;
  localparam int NUM_RAND_ROUNDS = 6;
  localparam int NUM_ROUNDS      = NUM_RAND_ROUNDS + 3;
  // every round may run 4 writers of 64 beats at up to 8 cycles per beat.
  localparam int TIMEOUT_CYCLES  = NUM_ROUNDS * N * REGION * 8 + `PERF_MEM_DEPTH + 16;

  logic                   clk;
  logic                   arst_n;
  logic [N-1:0]           start_req;
  run_cfg_t [N-1:0]       cfg;
  logic [N-1:0]           start_ack;
  run_stats_t [N-1:0]     stats;
  addr_t                  rd_addr;
  data_t                  rd_data;

  data_t       exp_mem [`PERF_MEM_DEPTH];     // reference copy of the sink memory.
  int          errors = 0;
  int          cycles = 0;
  int unsigned assert_fails;
  int          total;
  run_cfg_t [N-1:0] round_cfg;
  logic [N-1:0]     round_mask;

  perf_top u_dut (
    .clk      (clk),
    .arst_n   (arst_n),
    .start_req(start_req),
    .cfg      (cfg),
    .start_ack(start_ack),
    .stats    (stats),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic cnt_t beats_of(input run_cfg_t c);
    cnt_t nb;
    cnt_t bl;
    nb = (c.num_bursts == 4'd0) ? cnt_t'(1) : cnt_t'(c.num_bursts);
    bl = (c.burst_len == 4'd0) ? cnt_t'(1) : cnt_t'(c.burst_len);
    return nb * bl;
  endfunction

  task automatic update_model(input int id, input run_cfg_t c);
    int total_beats;
    total_beats = int'(beats_of(c));
    for (int k = 0; k < total_beats; k++) begin
      exp_mem[id * REGION + (k % REGION)] = {c.tag, 8'(id), 16'(k)};     // wraps in the region.
    end
  endtask

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic check_stats(input int id, input run_stats_t got, input cnt_t exp_beats);
    if (got.beats !== exp_beats) begin
      errors++;
      $display("Error: stats[%0d].beats got %h expected %h", id, got.beats, exp_beats);
    end
    if (int'(got.busy_cycles) < int'(got.beats) + int'(got.stall_cycles) ||
        got.stall_cycles >= got.busy_cycles) begin
      errors++;
      $display("writer %0d reported %0d busy cycles, which do not cover %0d beats and %0d stalls",
               id, got.busy_cycles, got.beats, got.stall_cycles);
    end
  endtask

  task automatic check_word(input addr_t a, input data_t got);
    if (got !== exp_mem[a]) begin
      errors++;
      $display("Error: rd_data at address %h got %h expected %h", a, got, exp_mem[a]);
    end
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  task automatic run_round(input logic [N-1:0] mask, input run_cfg_t [N-1:0] cfgs);
    logic [N-1:0] pending;
    logic [N-1:0] released;     // req dropped on the previous falling edge.
    @(negedge clk);
    cfg       = cfgs;
    start_req = mask;
    pending   = mask;
    released  = '0;
    @(negedge clk);
    if ((start_ack & mask) != '0) begin
      errors++;
      $display("start_ack was already high one cycle after start_req");
    end
    while (pending != '0) begin
      @(negedge clk);
      if ((start_ack & ~pending & ~released) != '0) begin
        errors++;
        $display("start_ack is high for a writer without a running request");
      end
      released = '0;
      for (int i = 0; i < N; i++) begin
        if (pending[i] && start_ack[i]) begin
          check_stats(i, stats[i], beats_of(cfgs[i]));
          update_model(i, cfgs[i]);
          start_req[i] = 1'b0;
          pending[i]   = 1'b0;
          released[i]  = 1'b1;
        end
      end
    end
    @(negedge clk);
    if (start_ack != '0) begin
      errors++;
      $display("start_ack did not fall after start_req dropped");
    end
  endtask

  // reads are pipelined, the data of one address arrives while the next is driven.
  task automatic read_back(input addr_t first, input int count);
    addr_t a;
    @(negedge clk);
    rd_addr = first;
    for (int k = 0; k < count; k++) begin
      a = first + addr_t'(k);
      @(negedge clk);
      check_word(a, rd_data);
      rd_addr = a + addr_t'(1);
    end
  endtask

  initial begin
    void'($urandom(32'h3e94_2f30));
    arst_n    = 1'b0;
    start_req = '0;
    cfg       = '0;
    rd_addr   = '0;
    for (int a = 0; a < `PERF_MEM_DEPTH; a++) begin
      exp_mem[a] = 'x;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // single beat from writer 0, checked at its region base.
    round_cfg    = '0;
    round_cfg[0] = run_cfg_t'{num_bursts: 4'd1, burst_len: 4'd1, tag: 8'h5a};
    run_round(4'b0001, round_cfg);
    read_back(addr_t'(0), 1);

    // all four writers fill their whole regions.
    for (int i = 0; i < N; i++) begin
      round_cfg[i] = run_cfg_t'{num_bursts: 4'd8, burst_len: 4'd8, tag: 8'($urandom)};
    end
    run_round('1, round_cfg);

    for (int r = 0; r < NUM_RAND_ROUNDS; r++) begin
      round_mask = N'($urandom_range(1, 2 ** N - 1));
      for (int i = 0; i < N; i++) begin
        round_cfg[i].num_bursts = 4'($urandom_range(0, 8));
        round_cfg[i].burst_len  = 4'($urandom_range(0, 8));
        round_cfg[i].tag        = 8'($urandom);
      end
      run_round(round_mask, round_cfg);
    end

    // 96 beats from writer 2 wrap past the end of its region.
    round_cfg    = '0;
    round_cfg[2] = run_cfg_t'{num_bursts: 4'd12, burst_len: 4'd8, tag: 8'hc3};
    run_round(4'b0100, round_cfg);

    read_back(addr_t'(0), `PERF_MEM_DEPTH);

    assert_fails = u_dut.u_arbiter.u_assert.failures;
    total        = errors + int'(assert_fails);
    $display("errors: %0d compare, %0d assertion", errors, assert_fails);
    if (total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+logic
logic/perf_pkg.sv
logic/burst_writer.sv
logic/write_arbiter.sv
logic/mem_sink.sv
logic/perf_top.sv
tb/perf_assertions.sv
tb/perf_tb.sv

/* Bender.yml */
package:
  name: perf_tester

sources:
  - include_dirs:
      - logic
    files:
      - logic/perf_pkg.sv
      - logic/burst_writer.sv
      - logic/write_arbiter.sv
      - logic/mem_sink.sv
      - logic/perf_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - tb/perf_assertions.sv
      - tb/perf_tb.sv
